/* logic/obi_pkg.sv */
// --------------------------------------
// data-bus side definitions
// observed OBI signal bundle, per-request
// attribute record, outstanding count type
// --------------------------------------

`default_nettype none

package obi_pkg;

  // signals seen on the data bus in one cycle
  typedef struct packed {
    logic req;
    logic gnt;
    logic rvalid;
    // inverted copy of gnt
    logic gntpar;
    logic is_store;
  } obi_bus_t;

  // attributes queued for each granted request
  typedef struct packed {
    logic is_store;
    logic gntpar_err;
  } req_attr_t;

  // number of granted addresses still waiting for a response
  typedef logic [3:0] obi_count_t;

  localparam obi_count_t OBI_COUNT_MAX = 4'd15;

endpackage

`default_nettype wire

/* logic/retire_pkg.sv */
// --------------------------------------
// retirement side definitions
// retirement report, debug FSM states,
// debug request hold counter type
// --------------------------------------

`default_nettype none

package retire_pkg;

  // one retirement report from writeback
  typedef struct packed {
    // single-cycle retirement strobe
    logic valid;
    logic dbg_mode;
    logic is_dret;
    logic trap;
  } retire_t;

  // tracks where the core is relative to debug code
  typedef enum logic [1:0] {
    DBG_NORMAL,
    DBG_IN_DEBUG,
    DBG_DRET_SEEN
  } dbg_state_e;

  // retirements left before a recorded debug request expires
  typedef logic [1:0] dbg_hold_t;

endpackage

`default_nettype wire

/* logic/obi_phase_monitor.sv */
// --------------------------------------
// OBI data-bus phase monitor
// address and response phase continuation,
// saturating outstanding-address count
// --------------------------------------

`default_nettype none

module obi_phase_monitor (
  input  logic                 in_support_if,
  input  logic                 reset_i,
  input  obi_pkg::obi_bus_t    bus_i,
  output logic                 gnt_q_o,
  output logic                 addr_ph_cont_o,
  output logic                 resp_ph_cont_o,
  output obi_pkg::obi_count_t  outstanding_o
);

  import obi_pkg::*;

  logic       req_no_gnt_q;
  logic       grant;
  obi_count_t count_q;

  assign grant = bus_i.req & bus_i.gnt;

  // previous cycle state of the address phase
  always_ff @(posedge in_support_if) begin
    if (reset_i) begin
      gnt_q_o      <= 1'b0;
      req_no_gnt_q <= 1'b0;
    end else begin
      gnt_q_o      <= bus_i.gnt;
      req_no_gnt_q <= bus_i.req & ~bus_i.gnt;
    end
  end

  // a request held over from a stalled cycle
  assign addr_ph_cont_o = bus_i.req & req_no_gnt_q;

  // --------------------------------------
  // outstanding address count
  // --------------------------------------

  // grant and rvalid in one cycle cancel out
  always_ff @(posedge in_support_if) begin
    if (reset_i) begin
      count_q <= '0;
    end else if (grant && !bus_i.rvalid) begin
      if (count_q != OBI_COUNT_MAX) begin
        count_q <= count_q + 1'b1;
      end
    end else if (bus_i.rvalid && !grant) begin
      if (count_q != '0) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // still waiting on at least one response
  assign resp_ph_cont_o = (count_q != '0) & ~bus_i.rvalid;
  assign outstanding_o  = count_q;

endmodule

`default_nettype wire

/* logic/gntpar_checker.sv */
// --------------------------------------
// grant parity checker
// flags gnt/gntpar mismatches and carries
// the flag across a stalled address phase
// --------------------------------------

`default_nettype none

module gntpar_checker (
  input  logic               in_support_if,
  input  logic               reset_i,
  input  obi_pkg::obi_bus_t  bus_i,
  output logic               gntpar_err_o
);

  logic carry_q;

  // gntpar must be the inverse of gnt while req is high
  assign gntpar_err_o = bus_i.req & ((bus_i.gnt == bus_i.gntpar) | carry_q);

  // keep the error alive until the stalled request is granted
  always_ff @(posedge in_support_if) begin
    if (reset_i) begin
      carry_q <= 1'b0;
    end else if (bus_i.req && !bus_i.gnt) begin
      carry_q <= gntpar_err_o;
    end else begin
      carry_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* logic/req_attr_fifo.sv */
// --------------------------------------
// in-order request attribute queue
// pushes on grant, shows the head entry
// in the response cycle and pops on rvalid
// --------------------------------------

`default_nettype none

module req_attr_fifo #(
  parameter int ATTR_DEPTH = 4
) (
  input  logic                in_support_if,
  input  logic                reset_i,
  input  logic                push_i,
  input  logic                pop_i,
  input  obi_pkg::req_attr_t  attr_i,
  output obi_pkg::req_attr_t  resp_attr_o
);

  import obi_pkg::*;

  localparam int PTR_W = $clog2(ATTR_DEPTH);
  localparam int CNT_W = $clog2(ATTR_DEPTH + 1);

  req_attr_t              mem [ATTR_DEPTH];
  logic [PTR_W-1:0]       wr_ptr_q;
  logic [PTR_W-1:0]       rd_ptr_q;
  logic [CNT_W-1:0]       count_q;
  logic                   empty;
  logic                   full;
  logic                   do_push;
  logic                   do_pop;

  assign empty = (count_q == '0);
  assign full  = (count_q == CNT_W'(ATTR_DEPTH));

  assign do_pop  = pop_i & ~empty;
  // a full queue still takes a push when the head leaves in the same cycle
  assign do_push = push_i & (~full | do_pop);

  // entry storage
  always_ff @(posedge in_support_if) begin
    if (do_push) begin
      mem[wr_ptr_q] <= attr_i;
    end
  end

  // --------------------------------------
  // pointers and occupancy
  // --------------------------------------

  always_ff @(posedge in_support_if) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // attributes of the oldest request while its response is on the bus
  assign resp_attr_o = do_pop ? mem[rd_ptr_q] : '0;

endmodule

`default_nettype wire

/* logic/retire_tracker.sv */
// --------------------------------------
// retirement tracker
// debug entry/exit FSM, debug request
// recording, request after exception
// --------------------------------------

`default_nettype none

module retire_tracker (
  input  logic                 in_support_if,
  input  logic                 reset_i,
  input  retire_pkg::retire_t  retire_i,
  input  logic                 trap_taken_i,
  input  logic                 debug_req_i,
  input  logic                 bus_req_i,
  input  logic                 gnt_q_i,
  output logic                 first_debug_ins_o,
  output logic                 recorded_dbg_req_o,
  output logic                 req_after_exception_o
);

  import retire_pkg::*;

  dbg_state_e state_q;
  dbg_state_e state_d;
  dbg_hold_t  hold_q;
  logic       exc_active_q;

  // --------------------------------------
  // debug entry and exit
  // --------------------------------------

  always_comb begin
    state_d = state_q;
    if (state_q == DBG_DRET_SEEN) begin
      // one cycle after dret, back to normal no matter what retires
      state_d = DBG_NORMAL;
    end else if (retire_i.valid) begin
      if (retire_i.is_dret && !retire_i.trap) begin
        state_d = DBG_DRET_SEEN;
      end else if (retire_i.dbg_mode) begin
        state_d = DBG_IN_DEBUG;
      end else begin
        state_d = DBG_NORMAL;
      end
    end
  end

  always_ff @(posedge in_support_if) begin
    if (reset_i) begin
      state_q <= DBG_NORMAL;
    end else begin
      state_q <= state_d;
    end
  end

  assign first_debug_ins_o = retire_i.valid & retire_i.dbg_mode & (state_q == DBG_NORMAL);

  // --------------------------------------
  // debug request recording
  // --------------------------------------

  // held for one more retirement with a coincident retire, two without
  always_ff @(posedge in_support_if) begin
    if (reset_i) begin
      recorded_dbg_req_o <= 1'b0;
      hold_q             <= '0;
    end else if (retire_i.valid) begin
      if (debug_req_i) begin
        recorded_dbg_req_o <= 1'b1;
        hold_q             <= 2'd1;
      end else if (hold_q != '0) begin
        hold_q <= hold_q - 1'b1;
      end else begin
        recorded_dbg_req_o <= 1'b0;
      end
    end else if (debug_req_i) begin
      recorded_dbg_req_o <= 1'b1;
      hold_q             <= 2'd2;
    end
  end

  // --------------------------------------
  // data request after a trap
  // --------------------------------------

  always_ff @(posedge in_support_if) begin
    if (reset_i) begin
      exc_active_q          <= 1'b0;
      req_after_exception_o <= 1'b0;
    end else if (trap_taken_i) begin
      exc_active_q <= 1'b1;
      if (bus_req_i && gnt_q_i) begin
        req_after_exception_o <= 1'b1;
      end
    end else if (retire_i.valid) begin
      exc_active_q          <= 1'b0;
      req_after_exception_o <= 1'b0;
    end else if (exc_active_q && bus_req_i && gnt_q_i) begin
      req_after_exception_o <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/support_logic.sv */
// --------------------------------------
// support logic top level
// data-bus watchers around the
// retirement tracker
// --------------------------------------

`default_nettype none

module support_logic #(
  parameter int ATTR_DEPTH = 4
) (
  input  logic                 in_support_if,
  input  logic                 reset_i,
  input  obi_pkg::obi_bus_t    bus_i,
  input  retire_pkg::retire_t  retire_i,
  input  logic                 trap_taken_i,
  input  logic                 debug_req_i,
  output logic                 addr_ph_cont_o,
  output logic                 resp_ph_cont_o,
  output obi_pkg::obi_count_t  outstanding_o,
  output obi_pkg::req_attr_t   resp_attr_o,
  output logic                 first_debug_ins_o,
  output logic                 recorded_dbg_req_o,
  output logic                 req_after_exception_o
);

  import obi_pkg::*;

  logic      gnt_q;
  logic      gntpar_err;
  req_attr_t push_attr;

  assign push_attr = '{is_store: bus_i.is_store, gntpar_err: gntpar_err};

  obi_phase_monitor u_phase (
    .in_support_if  (in_support_if),
    .reset_i        (reset_i),
    .bus_i          (bus_i),
    .gnt_q_o        (gnt_q),
    .addr_ph_cont_o (addr_ph_cont_o),
    .resp_ph_cont_o (resp_ph_cont_o),
    .outstanding_o  (outstanding_o)
  );

  gntpar_checker u_gntpar (
    .in_support_if (in_support_if),
    .reset_i       (reset_i),
    .bus_i         (bus_i),
    .gntpar_err_o  (gntpar_err)
  );

  // attributes enter on grant and leave with the matching rvalid
  req_attr_fifo #(
    .ATTR_DEPTH (ATTR_DEPTH)
  ) u_attr_fifo (
    .in_support_if (in_support_if),
    .reset_i       (reset_i),
    .push_i        (bus_i.req & bus_i.gnt),
    .pop_i         (bus_i.rvalid),
    .attr_i        (push_attr),
    .resp_attr_o   (resp_attr_o)
  );

  retire_tracker u_retire (
    .in_support_if         (in_support_if),
    .reset_i               (reset_i),
    .retire_i              (retire_i),
    .trap_taken_i          (trap_taken_i),
    .debug_req_i           (debug_req_i),
    .bus_req_i             (bus_i.req),
    .gnt_q_i               (gnt_q),
    .first_debug_ins_o     (first_debug_ins_o),
    .recorded_dbg_req_o    (recorded_dbg_req_o),
    .req_after_exception_o (req_after_exception_o)
  );

endmodule

`default_nettype wire

/* bench/support_logic_tb.sv */
// --------------------------------------
// testbench for the support logic block
// LFSR bus and retirement stimulus,
// reference model, concurrent assertions
// --------------------------------------

`default_nettype none

module support_logic_tb;

  import obi_pkg::*;
  import retire_pkg::*;

  // field order from the msb is req gnt rvalid gntpar is_store
  localparam obi_bus_t BUS_IDLE  = 5'b00010;
  localparam obi_bus_t BUS_GRANT = 5'b11000;
  localparam obi_bus_t BUS_RESP  = 5'b00110;
  // field order from the msb is valid dbg_mode is_dret trap
  localparam retire_t RET_NONE   = 4'b0000;
  localparam retire_t RET_NORMAL = 4'b1000;
  localparam retire_t RET_DEBUG  = 4'b1100;
  localparam retire_t RET_DRET   = 4'b1110;

  logic       in_support_if;
  logic       reset_i;
  obi_bus_t   bus;
  retire_t    retire;
  logic       trap_taken;
  logic       debug_req;
  logic       addr_ph_cont;
  logic       resp_ph_cont;
  obi_count_t outstanding;
  req_attr_t  resp_attr;
  logic       first_debug_ins;
  logic       recorded_dbg_req;
  logic       req_after_exception;
  logic [31:0] lfsr;
  int         bus_errors;
  int         retire_errors;
  int         timeouts;

  support_logic #(
    .ATTR_DEPTH (4)
  ) u_dut (
    .in_support_if         (in_support_if),
    .reset_i               (reset_i),
    .bus_i                 (bus),
    .retire_i              (retire),
    .trap_taken_i          (trap_taken),
    .debug_req_i           (debug_req),
    .addr_ph_cont_o        (addr_ph_cont),
    .resp_ph_cont_o        (resp_ph_cont),
    .outstanding_o         (outstanding),
    .resp_attr_o           (resp_attr),
    .first_debug_ins_o     (first_debug_ins),
    .recorded_dbg_req_o    (recorded_dbg_req),
    .req_after_exception_o (req_after_exception)
  );

  initial begin
    in_support_if = 1'b0;
    forever #5 in_support_if = ~in_support_if;
  end

  // --------------------------------------
  // reference model
  // --------------------------------------

  logic       prev_req;
  logic       prev_gnt;
  logic       carry_m;
  obi_count_t count_m;
  req_attr_t  attr_mem [16];
  logic [3:0] wr_n;
  logic [3:0] rd_n;
  dbg_state_e dbg_m;
  dbg_hold_t  hold_m;
  logic       record_m;
  logic       exc_m;
  logic       rae_m;
  logic       exp_err;
  logic       exp_addr_cont;
  logic       exp_resp_cont;
  logic       exp_first_dbg;
  req_attr_t  exp_attr;

  // expected values that follow the inputs of the current cycle
  always_comb begin
    exp_err       = bus.req && ((bus.gnt == bus.gntpar) || carry_m);
    exp_addr_cont = bus.req && prev_req && !prev_gnt;
    exp_resp_cont = (count_m != 4'd0) && !bus.rvalid;
    exp_attr      = (bus.rvalid && (wr_n != rd_n)) ? attr_mem[rd_n] : 2'b00;
    exp_first_dbg = retire.valid && retire.dbg_mode && (dbg_m == DBG_NORMAL);
  end

  always @(posedge in_support_if) begin
    if (reset_i) begin
      prev_req <= 1'b0;
      prev_gnt <= 1'b0;
      carry_m  <= 1'b0;
      count_m  <= 4'd0;
      wr_n     <= 4'd0;
      rd_n     <= 4'd0;
      dbg_m    <= DBG_NORMAL;
      hold_m   <= 2'd0;
      record_m <= 1'b0;
      exc_m    <= 1'b0;
      rae_m    <= 1'b0;
    end else begin
      prev_req <= bus.req;
      prev_gnt <= bus.gnt;
      carry_m  <= bus.req && !bus.gnt && exp_err;
      if (bus.req && bus.gnt) begin
        attr_mem[wr_n] <= '{is_store: bus.is_store, gntpar_err: exp_err};
        wr_n           <= wr_n + 4'd1;
      end
      if (bus.rvalid) begin
        rd_n <= rd_n + 4'd1;
      end
      if ((bus.req && bus.gnt) && !bus.rvalid && count_m != OBI_COUNT_MAX) begin
        count_m <= count_m + 4'd1;
      end else if (bus.rvalid && !(bus.req && bus.gnt) && count_m != 4'd0) begin
        count_m <= count_m - 4'd1;
      end
      // dret leaves debug for exactly one cycle
      if (dbg_m == DBG_DRET_SEEN) begin
        dbg_m <= DBG_NORMAL;
      end else if (retire.valid && retire.is_dret && !retire.trap) begin
        dbg_m <= DBG_DRET_SEEN;
      end else if (retire.valid && retire.dbg_mode) begin
        dbg_m <= DBG_IN_DEBUG;
      end else if (retire.valid) begin
        dbg_m <= DBG_NORMAL;
      end
      if (debug_req) begin
        record_m <= 1'b1;
        hold_m   <= retire.valid ? 2'd1 : 2'd2;
      end else if (retire.valid && hold_m == 2'd0) begin
        record_m <= 1'b0;
      end else if (retire.valid) begin
        hold_m <= hold_m - 2'd1;
      end
      if (trap_taken) begin
        exc_m <= 1'b1;
        if (bus.req && prev_gnt) begin
          rae_m <= 1'b1;
        end
      end else if (retire.valid) begin
        exc_m <= 1'b0;
        rae_m <= 1'b0;
      end else if (exc_m && bus.req && prev_gnt) begin
        rae_m <= 1'b1;
      end
    end
  end

  // --------------------------------------
  // checks against the model
  // --------------------------------------

  assert property (@(posedge in_support_if) disable iff (reset_i)
    resp_attr.is_store == exp_attr.is_store)
    else begin
      bus_errors++;
      $display("Error: resp_attr_o.is_store expected %h actual %h",
               $sampled(exp_attr.is_store), $sampled(resp_attr.is_store));
    end

  assert property (@(posedge in_support_if) disable iff (reset_i)
    resp_attr.gntpar_err == exp_attr.gntpar_err)
    else begin
      bus_errors++;
      $display("Error: resp_attr_o.gntpar_err expected %h actual %h",
               $sampled(exp_attr.gntpar_err), $sampled(resp_attr.gntpar_err));
    end

  assert property (@(posedge in_support_if) disable iff (reset_i)
    addr_ph_cont == exp_addr_cont)
    else begin
      bus_errors++;
      $display("Error: addr_ph_cont_o expected %h actual %h",
               $sampled(exp_addr_cont), $sampled(addr_ph_cont));
    end

  assert property (@(posedge in_support_if) disable iff (reset_i)
    resp_ph_cont == exp_resp_cont)
    else begin
      bus_errors++;
      $display("Error: resp_ph_cont_o expected %h actual %h",
               $sampled(exp_resp_cont), $sampled(resp_ph_cont));
    end

  assert property (@(posedge in_support_if) disable iff (reset_i)
    outstanding == count_m)
    else begin
      bus_errors++;
      $display("Error: outstanding_o expected %h actual %h",
               $sampled(count_m), $sampled(outstanding));
    end

  assert property (@(posedge in_support_if) disable iff (reset_i)
    req_after_exception == rae_m)
    else begin
      retire_errors++;
      $display("Error: req_after_exception_o expected %h actual %h",
               $sampled(rae_m), $sampled(req_after_exception));
    end

  assert property (@(posedge in_support_if) disable iff (reset_i)
    first_debug_ins == exp_first_dbg)
    else begin
      retire_errors++;
      $display("Error: first_debug_ins_o expected %h actual %h",
               $sampled(exp_first_dbg), $sampled(first_debug_ins));
    end

  assert property (@(posedge in_support_if) disable iff (reset_i)
    recorded_dbg_req == record_m)
    else begin
      retire_errors++;
      $display("Error: recorded_dbg_req_o expected %h actual %h",
               $sampled(record_m), $sampled(recorded_dbg_req));
    end

  // --------------------------------------
  // stimulus helpers
  // --------------------------------------

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'hB4BC_D35C;
    end
    return s >> 1;
  endfunction

  task automatic rand_bits(input int n, output logic [15:0] v);
    int i;
    begin
      v = 16'h0;
      for (i = 0; i < n; i++) begin
        v[i] = lfsr[0];
        lfsr = lfsr_step(lfsr);
      end
    end
  endtask

  task automatic step(input obi_bus_t b, input retire_t r, input logic trap, input logic dreq);
    begin
      @(negedge in_support_if);
      bus        = b;
      retire     = r;
      trap_taken = trap;
      debug_req  = dreq;
    end
  endtask

  // one cycle of random traffic with at most 4 requests in flight
  task automatic random_cycle();
    logic [15:0] r;
    logic        stalled;
    begin
      @(negedge in_support_if);
      stalled = bus.req && !bus.gnt;
      rand_bits(14, r);
      if (!stalled) begin
        bus.req      = r[0];
        bus.is_store = r[1];
      end
      bus.rvalid        = (count_m != 4'd0) && r[3];
      bus.gnt           = bus.req && r[2] && ((count_m < 4'd4) || bus.rvalid);
      // roughly one corrupted parity bit in eight
      bus.gntpar        = (r[6:4] == 3'b000) ? bus.gnt : !bus.gnt;
      retire.valid      = (r[8:7] == 2'b00);
      retire.dbg_mode   = r[9];
      retire.is_dret    = r[10];
      retire.trap       = r[11];
      trap_taken        = (r[13:12] == 2'b00) && r[9];
      debug_req         = (r[13:12] == 2'b11) && r[10];
    end
  endtask

  task automatic drain_bus();
    int   n;
    logic done;
    begin
      n    = 0;
      done = 1'b0;
      while (!done && n < 20) begin
        @(negedge in_support_if);
        retire     = RET_NONE;
        trap_taken = 1'b0;
        debug_req  = 1'b0;
        bus        = (count_m != 4'd0) ? BUS_RESP : BUS_IDLE;
        done       = (count_m == 4'd0);
        n++;
      end
      if (!done) begin
        timeouts++;
        $display("timeout: responses still outstanding after draining the bus");
      end
    end
  endtask

  task automatic wait_for_rae();
    int n;
    begin
      n = 0;
      while (!req_after_exception && n < 10) begin
        step(BUS_IDLE, RET_NONE, 1'b0, 1'b0);
        n++;
      end
      if (!req_after_exception) begin
        timeouts++;
        $display("timeout: request after exception was never flagged");
      end
    end
  endtask

  task automatic wait_for_record_clear();
    int n;
    begin
      n = 0;
      // the record shows up one clock after the request
      step(BUS_IDLE, RET_NONE, 1'b0, 1'b0);
      while (recorded_dbg_req && n < 8) begin
        step(BUS_IDLE, RET_NORMAL, 1'b0, 1'b0);
        step(BUS_IDLE, RET_NONE, 1'b0, 1'b0);
        n++;
      end
      if (recorded_dbg_req) begin
        timeouts++;
        $display("timeout: recorded debug request never cleared");
      end
    end
  endtask

  // --------------------------------------
  // test sequence
  // --------------------------------------

  initial begin
    bus           = BUS_IDLE;
    retire        = RET_NONE;
    trap_taken    = 1'b0;
    debug_req     = 1'b0;
    reset_i       = 1'b1;
    lfsr          = 32'h82c0;
    bus_errors    = 0;
    retire_errors = 0;
    timeouts      = 0;
    repeat (3) @(posedge in_support_if);
    @(negedge in_support_if);
    reset_i = 1'b0;

    repeat (600) random_cycle();
    drain_bus();
    step(BUS_IDLE, RET_NORMAL, 1'b0, 1'b0);
    step(BUS_IDLE, RET_NORMAL, 1'b0, 1'b0);
    step(BUS_IDLE, RET_NORMAL, 1'b0, 1'b0);

    // trap followed by two granted requests
    step(BUS_IDLE, RET_NONE, 1'b1, 1'b0);
    step(BUS_GRANT, RET_NONE, 1'b0, 1'b0);
    step(BUS_GRANT, RET_NONE, 1'b0, 1'b0);
    wait_for_rae();
    drain_bus();
    step(BUS_IDLE, RET_NORMAL, 1'b0, 1'b0);
    // trap in the same cycle as a request after a grant
    step(BUS_GRANT, RET_NONE, 1'b0, 1'b0);
    step(BUS_GRANT, RET_NONE, 1'b1, 1'b0);
    wait_for_rae();
    drain_bus();
    step(BUS_IDLE, RET_NORMAL, 1'b0, 1'b0);
    // trap with no request after it
    step(BUS_IDLE, RET_NONE, 1'b1, 1'b0);
    repeat (4) step(BUS_IDLE, RET_NONE, 1'b0, 1'b0);
    step(BUS_IDLE, RET_NORMAL, 1'b0, 1'b0);

    // enter debug, leave by dret and enter again
    step(BUS_IDLE, RET_DEBUG, 1'b0, 1'b0);
    step(BUS_IDLE, RET_DEBUG, 1'b0, 1'b0);
    step(BUS_IDLE, RET_DRET, 1'b0, 1'b0);
    step(BUS_IDLE, RET_NONE, 1'b0, 1'b0);
    step(BUS_IDLE, RET_NORMAL, 1'b0, 1'b0);
    step(BUS_IDLE, RET_DEBUG, 1'b0, 1'b0);
    step(BUS_IDLE, RET_DRET, 1'b0, 1'b0);
    step(BUS_IDLE, RET_DEBUG, 1'b0, 1'b0);
    step(BUS_IDLE, RET_DEBUG, 1'b0, 1'b0);
    step(BUS_IDLE, RET_NORMAL, 1'b0, 1'b0);

    // debug request with and without a coincident retirement
    step(BUS_IDLE, RET_NORMAL, 1'b0, 1'b1);
    wait_for_record_clear();
    step(BUS_IDLE, RET_NONE, 1'b0, 1'b1);
    wait_for_record_clear();
    repeat (2) step(BUS_IDLE, RET_NONE, 1'b0, 1'b0);

    $display("errors: bus %0d, retirement %0d, timeouts %0d",
             bus_errors, retire_errors, timeouts);
    if (bus_errors + retire_errors + timeouts == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
logic/obi_pkg.sv
logic/retire_pkg.sv
logic/obi_phase_monitor.sv
logic/gntpar_checker.sv
logic/req_attr_fifo.sv
logic/retire_tracker.sv
logic/support_logic.sv
bench/support_logic_tb.sv

/* run.sh */
#!/bin/sh
# build and run the support logic testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module support_logic_tb -f tb.f -o support_logic_sim
./obj_dir/support_logic_sim | tee sim.log

if grep -q "Test failures found" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
echo "simulation clean"
